// File: src.f
source/sdhc_reg_pkg.sv
source/sdhc_cmd_pkg.sv
source/sdhc_regs.sv
source/sdhc_clk_div.sv
source/sdhc_cmd_engine.sv
source/sdhc_top.sv
tests/sdhc_cmd_assert.sv
tests/tb_sdhc.sv

// File: Bender.yml
package:
  name: sdhc_cmd

sources:
  - source/sdhc_reg_pkg.sv
  - source/sdhc_cmd_pkg.sv
  - source/sdhc_regs.sv
  - source/sdhc_clk_div.sv
  - source/sdhc_cmd_engine.sv
  - source/sdhc_top.sv
  - target: test
    files:
      - tests/sdhc_cmd_assert.sv
      - tests/tb_sdhc.sv

// File: tests/tb_sdhc.sv
// ========================================
// Testbench for the SD host command line
// Card model, register model, random tests
// ========================================
`timescale 1ns/10ps

module tb_sdhc
  import sdhc_reg_pkg::*;
  import sdhc_cmd_pkg::*;
();

  localparam int DIV_WIDTH    = 8;
  localparam int RESP_TIMEOUT = 64;
  localparam int NUM_CMDS     = 300;
  localparam int MAX_DIV      = 3;
  localparam int CLK_PERIOD   = 10;
  localparam int CYCLE_LIMIT  = NUM_CMDS * ((2 * FRAME_BITS + RESP_TIMEOUT) * 2 * (MAX_DIV + 1)
                                            + 100) + 20000;

  // The first four command kinds get a card reply
  localparam int K_GOOD    = 0;
  localparam int K_CRC     = 1;
  localparam int K_INDEX   = 2;
  localparam int K_END     = 3;
  localparam int K_SILENT  = 4;
  localparam int K_NO_RESP = 5;
  localparam int K_SOFTRST = 6;

  logic                  clk_i = 1'b0;
  logic                  software_reset_cmd_q;
  logic                  reg_we_i;
  logic                  reg_re_i;
  reg_addr_t             reg_addr_i;
  reg_data_t             reg_wdata_i;
  reg_data_t             reg_rdata_o;
  logic                  reg_rvalid_o;
  logic                  sd_clk_o;
  logic                  sd_cmd_o;
  logic                  sd_cmd_oe_o;
  logic                  sd_cmd_i;
  logic                  interrupt_o;
  logic                  card_reply = 1'b0;
  int                    card_fault = K_GOOD;
  int                    card_delay = 2;
  int                    frames_seen = 0;
  logic [FRAME_BITS-1:0] last_frame;
  int                    mismatches = 0;
  int                    failures = 0;
  int                    cycles = 0;

  sdhc_top #(
    .DivWidth    (DIV_WIDTH),
    .RespTimeout (RESP_TIMEOUT)
  ) DUT (
    .clk_i,
    .software_reset_cmd_q,
    .reg_we_i,
    .reg_re_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .reg_rvalid_o,
    .sd_clk_o,
    .sd_cmd_o,
    .sd_cmd_oe_o,
    .sd_cmd_i,
    .interrupt_o
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped at the cycle limit of %0d before all tests finished", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_status(input cmd_err_t got_err, input logic got_done,
                              input cmd_err_t exp_err, input logic exp_done);
    if (got_err !== exp_err || got_done !== exp_done) begin
      mismatches++;
      $display("mismatch int_status: got err %h done %h, expected err %h done %h",
               got_err, got_done, exp_err, exp_done);
    end
  endtask

  task automatic check_frame(input logic [FRAME_BITS-1:0] got,
                             input logic [FRAME_BITS-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch sd_cmd_o frame: got %h, expected %h", got, exp);
    end
  endtask

  // Long division by x^7+x^3+1
  function automatic crc7_t crc7_calc(input logic [CRC_FIRST-1:0] bits);
    logic [CRC_FIRST+CRC_BITS-1:0] rem;
    rem = {bits, {CRC_BITS{1'b0}}};
    for (int i = CRC_FIRST + CRC_BITS - 1; i >= CRC_BITS; i--) begin
      if (rem[i]) begin
        rem[i -: 8] = rem[i -: 8] ^ 8'h89;
      end
    end
    return rem[CRC_BITS-1:0];
  endfunction

  function automatic logic [FRAME_BITS-1:0] cmd_frame(input cmd_index_t idx,
                                                      input reg_data_t arg);
    logic [CRC_FIRST-1:0] head;
    head = {START_BIT, DIR_HOST, idx, arg};
    return {head, crc7_calc(head), END_BIT};
  endfunction

  function automatic logic [INT_BITS-1:0] int_bits(input cmd_err_t err, input logic done);
    logic [INT_BITS-1:0] bits;
    bits                   = '0;
    bits[INT_CMD_COMPLETE] = done;
    bits[INT_TIMEOUT]      = err[ERR_TIMEOUT];
    bits[INT_CRC]          = err[ERR_CRC];
    bits[INT_END_BIT]      = err[ERR_END_BIT];
    bits[INT_INDEX]        = err[ERR_INDEX];
    return bits;
  endfunction

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk_i);
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_we_i = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    @(negedge clk_i);
    reg_re_i   = 1'b1;
    reg_addr_i = addr;
    @(negedge clk_i);
    reg_re_i = 1'b0;
    if (reg_rvalid_o !== 1'b1) begin
      failures++;
      $display("read of address %0d gave no valid strobe one cycle later", addr);
    end
    data = reg_rdata_o;
  endtask

  // Replies with the inverted argument and the chosen fault
  task automatic card_respond(input logic [FRAME_BITS-1:0] cmd);
    logic [FRAME_BITS-1:0] resp;
    crc7_t                 crc;
    cmd_index_t            idx;
    idx = cmd[FRAME_BITS-3 -: INDEX_BITS];
    if (card_fault == K_INDEX) begin
      idx = idx + 1'b1;
    end
    resp = {START_BIT, 1'b0, idx, ~cmd[CRC_FIRST-1 -: 32], {CRC_BITS{1'b0}}, END_BIT};
    crc  = '0;
    for (int i = FRAME_BITS - 1; i > CRC_BITS; i--) begin
      crc = crc7_next(crc, resp[i]);
    end
    resp[CRC_BITS:1] = crc;
    if (card_fault == K_CRC) begin
      resp[1] = ~resp[1];
    end
    if (card_fault == K_END) begin
      resp[0] = ~END_BIT;
    end
    repeat (card_delay) @(negedge sd_clk_o);
    for (int i = FRAME_BITS - 1; i >= 0; i--) begin
      @(negedge sd_clk_o);
      @(negedge clk_i);
      sd_cmd_i = resp[i];
    end
    @(negedge sd_clk_o);
    @(negedge clk_i);
    sd_cmd_i = 1'b1;
  endtask

  initial begin : card_model
    logic [FRAME_BITS-1:0] got;
    logic                  aborted;
    forever begin
      @(posedge sd_clk_o);
      if (sd_cmd_oe_o === 1'b1 && sd_cmd_o === START_BIT) begin
        got     = '0;
        aborted = 1'b0;
        for (int i = 1; i < FRAME_BITS && !aborted; i++) begin
          @(posedge sd_clk_o);
          aborted = !sd_cmd_oe_o;  // Host reset mid frame
          got     = {got[FRAME_BITS-2:0], sd_cmd_o};
        end
        if (!aborted) begin
          last_frame = got;
          frames_seen++;
          if (card_reply) begin
            card_respond(got);
          end
        end
      end
    end
  end

  task automatic register_test();
    reg_data_t rd;
    reg_data_t val;
    for (int n = 0; n < 12; n++) begin
      val = $urandom();
      case (n % 3)
        0: begin
          reg_write(ADDR_ARGUMENT, val);
          reg_read(ADDR_ARGUMENT, rd);
          check_data("argument", rd, val);
        end
        1: begin
          reg_write(ADDR_INT_ENABLE, val);
          reg_read(ADDR_INT_ENABLE, rd);
          check_data("int_enable", rd, val & reg_data_t'((1 << INT_BITS) - 1));
        end
        default: begin
          reg_write(ADDR_CLOCK_CTRL, val);
          reg_read(ADDR_CLOCK_CTRL, rd);
          // Stable follows the enable
          check_data("clock_ctrl", rd,
                     reg_data_t'({val[CLK_EN_BIT], val[CLK_EN_BIT], val[DIV_WIDTH-1:0]}));
        end
      endcase
    end
  endtask

  task automatic divider_test();
    reg_data_t rd;
    int        div;
    time       t0;
    time       t1;
    for (int n = 0; n < 8; n++) begin
      div = $urandom_range(MAX_DIV, 0);
      reg_write(ADDR_CLOCK_CTRL, reg_data_t'((1 << CLK_EN_BIT) | div));
      reg_read(ADDR_CLOCK_CTRL, rd);
      check_data("clock_ctrl enabled", rd,
                 reg_data_t'((1 << CLK_STABLE_BIT) | (1 << CLK_EN_BIT) | div));
      @(posedge sd_clk_o);  // First period may be short
      @(posedge sd_clk_o);
      t0 = $time;
      @(posedge sd_clk_o);
      t1 = $time;
      check_data("sd_clk_o period", reg_data_t'((t1 - t0) / CLK_PERIOD),
                 reg_data_t'(2 * (div + 1)));
    end
  endtask

  task automatic soft_reset_test(input int seen);
    reg_data_t rd;
    do begin
      @(negedge clk_i);
    end while (sd_cmd_oe_o !== 1'b1);
    repeat ($urandom_range(40, 0)) @(negedge clk_i);
    reg_write(ADDR_SOFT_RESET, reg_data_t'(1));
    repeat (2) @(negedge clk_i);
    check_data("sd_cmd_oe_o after soft reset", reg_data_t'(sd_cmd_oe_o), '0);
    reg_read(ADDR_PRESENT, rd);
    check_data("present after soft reset", rd, '0);
    reg_read(ADDR_SOFT_RESET, rd);
    check_data("soft_reset", rd, '0);
    reg_read(ADDR_INT_STATUS, rd);
    check_data("int_status after soft reset", rd, '0);
    check_data("frames after soft reset", reg_data_t'(frames_seen - seen), '0);
  endtask

  task automatic command_test();
    reg_data_t           arg;
    reg_data_t           int_en;
    reg_data_t           rd;
    cmd_index_t          idx;
    cmd_err_t            exp_err;
    cmd_err_t            got_err;
    logic [INT_BITS-1:0] exp_int;
    logic                resp;
    int                  kind;
    int                  seen;
    arg    = $urandom();
    idx    = cmd_index_t'($urandom());
    int_en = $urandom_range((1 << INT_BITS) - 1, 0);
    kind   = $urandom_range(K_SOFTRST, K_GOOD);
    resp   = (kind != K_NO_RESP);
    reg_write(ADDR_CLOCK_CTRL, reg_data_t'((1 << CLK_EN_BIT) | $urandom_range(MAX_DIV, 0)));
    reg_write(ADDR_ARGUMENT, arg);
    reg_write(ADDR_INT_ENABLE, int_en);
    card_fault = kind;
    card_delay = $urandom_range(10, 2);
    card_reply = (kind < K_SILENT);
    seen       = frames_seen;
    reg_write(ADDR_COMMAND, reg_data_t'({resp, 2'b00, idx}));
    if ($urandom_range(3, 0) == 0) begin
      // Dropped while busy
      reg_write(ADDR_COMMAND, reg_data_t'(~idx));
      reg_read(ADDR_COMMAND, rd);
      check_data("command while inhibited", rd, reg_data_t'({resp, 2'b00, idx}));
    end
    if (kind == K_SOFTRST) begin
      soft_reset_test(seen);
    end else begin
      do begin
        reg_read(ADDR_INT_STATUS, rd);
      end while (rd == '0);
      exp_err = '0;
      case (kind)
        K_CRC:    exp_err[ERR_CRC] = 1'b1;
        K_INDEX:  exp_err[ERR_INDEX] = 1'b1;
        K_END:    exp_err[ERR_END_BIT] = 1'b1;
        K_SILENT: exp_err[ERR_TIMEOUT] = 1'b1;
        default:  exp_err = '0;
      endcase
      exp_int = int_bits(exp_err, kind != K_SILENT);
      got_err[ERR_TIMEOUT] = rd[INT_TIMEOUT];
      got_err[ERR_CRC]     = rd[INT_CRC];
      got_err[ERR_END_BIT] = rd[INT_END_BIT];
      got_err[ERR_INDEX]   = rd[INT_INDEX];
      check_status(got_err, rd[INT_CMD_COMPLETE], exp_err, kind != K_SILENT);
      check_data("interrupt_o", reg_data_t'(interrupt_o),
                 reg_data_t'(|(exp_int & int_en[INT_BITS-1:0])));
      check_data("frames per command", reg_data_t'(frames_seen - seen), reg_data_t'(1));
      check_frame(last_frame, cmd_frame(idx, arg));
      if (kind == K_GOOD) begin
        reg_read(ADDR_RESPONSE, rd);
        check_data("response", rd, ~arg);
      end
      if (kind == K_SILENT) begin
        reg_read(ADDR_PRESENT, rd);
        check_data("present after timeout", rd, '0);
      end
      reg_write(ADDR_INT_STATUS, '1);
      reg_read(ADDR_INT_STATUS, rd);
      check_data("int_status after clear", rd, '0);
      check_data("interrupt_o after clear", reg_data_t'(interrupt_o), '0);
    end
  endtask

  initial begin : stimulus
    software_reset_cmd_q = 1'b1;
    reg_we_i             = 1'b0;
    reg_re_i             = 1'b0;
    reg_addr_i           = '0;
    reg_wdata_i          = '0;
    sd_cmd_i             = 1'b1;  // Pulled up
    void'($urandom(30));
    repeat (16) @(negedge clk_i);
    software_reset_cmd_q = 1'b0;
    check_data("outputs after reset",
               reg_data_t'({sd_clk_o, sd_cmd_o, sd_cmd_oe_o, interrupt_o, reg_rvalid_o}),
               reg_data_t'(5'b01000));
    register_test();
    divider_test();
    for (int n = 0; n < NUM_CMDS; n++) begin
      command_test();
    end
    $display("mismatches: %0d, other errors: %0d, assertion failures: %0d",
             mismatches, failures, DUT.i_cmd_engine.u_cmd_assert.fail_cnt);
    if (mismatches == 0 && failures == 0 && DUT.i_cmd_engine.u_cmd_assert.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: tests/sdhc_cmd_assert.sv
// ========================================
// Concurrent checks on the CMD line engine
// ========================================
`timescale 1ns/10ps

module sdhc_cmd_assert (
  input logic clk_i,
  input logic rst_i,
  input logic in_send_i,
  input logic cmd_line_i,
  input logic cmd_oe_i,
  input logic cmd_done_i
);

  int fail_cnt = 0;

  // Driver only turns on while a frame goes out
  oe_rise_in_send: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(cmd_oe_i) |-> $past(in_send_i))
  else begin
    fail_cnt++;
    $error("command line driver enabled outside the send state");
  end

  done_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_done_i |=> !cmd_done_i)
  else begin
    fail_cnt++;
    $error("command done strobe lasted longer than one cycle");
  end

  // Release happens after the end bit, not after a reset
  end_bit_before_release: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(cmd_oe_i) && !$past(rst_i) |-> $past(cmd_line_i))
  else begin
    fail_cnt++;
    $error("command line released without a high end bit");
  end

endmodule

bind sdhc_cmd_engine sdhc_cmd_assert u_cmd_assert (
  .clk_i      (clk_i),
  .rst_i      (cmd_line_rst_i),
  .in_send_i  (state_q == ST_SEND),
  .cmd_line_i (sd_cmd_o),
  .cmd_oe_i   (sd_cmd_oe_o),
  .cmd_done_i (cmd_done_o)
);

// File: source/sdhc_top.sv
// ======================================
// SD host controller, command line only
// ======================================
`timescale 1ns/10ps

module sdhc_top
  import sdhc_reg_pkg::*;
  import sdhc_cmd_pkg::*;
#(
  parameter int DivWidth    = 8,
  parameter int RespTimeout = 64
) (
  input  logic      clk_i,
  input  logic      software_reset_cmd_q,
  input  logic      reg_we_i,
  input  logic      reg_re_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  output logic      reg_rvalid_o,
  output logic      sd_clk_o,
  output logic      sd_cmd_o,
  output logic      sd_cmd_oe_o,
  input  logic      sd_cmd_i,
  output logic      interrupt_o
);

  logic                soft_rst_cmd;
  logic                soft_rst_cmd_q;
  logic                cmd_line_rst;
  logic                cmd_start;
  logic                resp_en;
  logic                clk_en;
  logic                sd_rise;
  logic                sd_fall;
  logic                sd_stable;
  logic                cmd_busy;
  logic                cmd_done;
  logic [DivWidth-1:0] div;
  cmd_index_t          cmd_index;
  reg_data_t           cmd_arg;
  reg_data_t           resp_status;
  cmd_err_t            cmd_err;

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      soft_rst_cmd_q <= 1'b0;
    end else begin
      soft_rst_cmd_q <= soft_rst_cmd;
    end
  end

  assign cmd_line_rst = software_reset_cmd_q | soft_rst_cmd_q;  // Engine only

  sdhc_regs #(
    .DivWidth (DivWidth)
  ) i_regs (
    .clk_i,
    .software_reset_cmd_q,
    .reg_we_i,
    .reg_re_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .reg_rvalid_o,
    .sd_stable_i    (sd_stable),
    .cmd_busy_i     (cmd_busy),
    .cmd_done_i     (cmd_done),
    .cmd_err_i      (cmd_err),
    .resp_status_i  (resp_status),
    .cmd_start_o    (cmd_start),
    .cmd_index_o    (cmd_index),
    .cmd_arg_o      (cmd_arg),
    .resp_en_o      (resp_en),
    .div_o          (div),
    .clk_en_o       (clk_en),
    .soft_rst_cmd_o (soft_rst_cmd),
    .interrupt_o
  );

  sdhc_clk_div #(
    .DivWidth (DivWidth)
  ) i_clk_div (
    .clk_i,
    .software_reset_cmd_q,
    .div_i       (div),
    .clk_en_i    (clk_en),
    .sd_clk_o,
    .sd_rise_o   (sd_rise),
    .sd_fall_o   (sd_fall),
    .sd_stable_o (sd_stable)
  );

  sdhc_cmd_engine #(
    .RespTimeout (RespTimeout)
  ) i_cmd_engine (
    .clk_i,
    .cmd_line_rst_i (cmd_line_rst),
    .sd_rise_i      (sd_rise),
    .sd_fall_i      (sd_fall),
    .cmd_start_i    (cmd_start),
    .cmd_index_i    (cmd_index),
    .cmd_arg_i      (cmd_arg),
    .resp_en_i      (resp_en),
    .sd_cmd_i,
    .sd_cmd_o,
    .sd_cmd_oe_o,
    .cmd_busy_o     (cmd_busy),
    .cmd_done_o     (cmd_done),
    .cmd_err_o      (cmd_err),
    .resp_status_o  (resp_status)
  );

endmodule

// File: source/sdhc_cmd_engine.sv
// ======================================
// CMD line engine: 48-bit send/receive
// CRC7 generation and response checks
// ======================================
`timescale 1ns/10ps

module sdhc_cmd_engine
  import sdhc_reg_pkg::*;
  import sdhc_cmd_pkg::*;
#(
  parameter int RespTimeout = 64
) (
  input  logic       clk_i,
  input  logic       cmd_line_rst_i,
  input  logic       sd_rise_i,
  input  logic       sd_fall_i,
  input  logic       cmd_start_i,
  input  cmd_index_t cmd_index_i,
  input  reg_data_t  cmd_arg_i,
  input  logic       resp_en_i,
  input  logic       sd_cmd_i,
  output logic       sd_cmd_o,
  output logic       sd_cmd_oe_o,
  output logic       cmd_busy_o,
  output logic       cmd_done_o,
  output cmd_err_t   cmd_err_o,
  output reg_data_t  resp_status_o
);

  localparam int CntWidth = $clog2(FRAME_BITS + 1);
  localparam int ToWidth  = $clog2(RespTimeout + 1);
  localparam int RxBits   = FRAME_BITS - 2;  // Frame minus start and end bit

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND,
    ST_WAIT,
    ST_RECV,
    ST_DONE
  } state_e;

  state_e               state_q;
  logic [CntWidth-1:0]  bit_cnt_q;
  logic [ToWidth-1:0]   wait_cnt_q;
  logic                 resp_en_q;
  logic [CRC_FIRST-1:0] tx_shift_q;
  logic [RxBits-1:0]    rx_shift_q;
  cmd_index_t           sent_index_q;
  crc7_t                crc_q;
  logic                 tx_bit;
  logic                 start_cmd;
  logic                 send_bit;
  logic                 resp_start;
  logic                 recv_bit;
  logic                 crc_covered;
  cmd_index_t           rx_index;
  crc7_t                rx_crc;

  assign start_cmd   = (state_q == ST_IDLE) && cmd_start_i;
  assign send_bit    = (state_q == ST_SEND) && sd_fall_i && (bit_cnt_q < CntWidth'(FRAME_BITS));
  assign resp_start  = (state_q == ST_WAIT) && sd_rise_i && (sd_cmd_i == START_BIT);
  assign recv_bit    = (state_q == ST_RECV) && sd_rise_i;
  assign crc_covered = bit_cnt_q < CntWidth'(CRC_FIRST);

  // Fields of the response, valid once the end bit arrives
  assign rx_index = rx_shift_q[RxBits-2 -: INDEX_BITS];
  assign rx_crc   = rx_shift_q[CRC_BITS-1:0];

  always_comb begin
    if (crc_covered) begin
      tx_bit = tx_shift_q[CRC_FIRST-1];
    end else if (bit_cnt_q < CntWidth'(END_BIT_POS)) begin
      tx_bit = crc_q[CRC_BITS-1];
    end else begin
      tx_bit = END_BIT;
    end
  end

  // Frame data and CRC, shared by both directions
  always_ff @(posedge clk_i) begin
    if (start_cmd) begin
      tx_shift_q   <= {START_BIT, DIR_HOST, cmd_index_i, cmd_arg_i};
      sent_index_q <= cmd_index_i;
      crc_q        <= '0;
    end else if (send_bit) begin
      tx_shift_q <= tx_shift_q << 1;
      crc_q      <= crc_covered ? crc7_next(crc_q, tx_bit) : crc_q << 1;
    end else if (resp_start) begin
      crc_q <= crc7_next('0, START_BIT);
    end else if (recv_bit) begin
      rx_shift_q <= {rx_shift_q[RxBits-2:0], sd_cmd_i};
      if (crc_covered) begin
        crc_q <= crc7_next(crc_q, sd_cmd_i);
      end
      if (bit_cnt_q == CntWidth'(END_BIT_POS)) begin
        resp_status_o <= rx_shift_q[CRC_BITS +: $bits(reg_data_t)];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_line_rst_i) begin
      state_q     <= ST_IDLE;
      bit_cnt_q   <= '0;
      wait_cnt_q  <= '0;
      resp_en_q   <= 1'b0;
      sd_cmd_o    <= 1'b1;
      sd_cmd_oe_o <= 1'b0;
      cmd_err_o   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_cmd) begin
            state_q   <= ST_SEND;
            bit_cnt_q <= '0;
            resp_en_q <= resp_en_i;
            cmd_err_o <= '0;
          end
        end
        ST_SEND: begin
          if (send_bit) begin
            sd_cmd_oe_o <= 1'b1;
            sd_cmd_o    <= tx_bit;
            bit_cnt_q   <= bit_cnt_q + 1'b1;
          end else if (sd_fall_i) begin
            // End bit has been on the line for a full SD clock
            sd_cmd_oe_o <= 1'b0;
            wait_cnt_q  <= '0;
            state_q     <= resp_en_q ? ST_WAIT : ST_DONE;
          end
        end
        ST_WAIT: begin
          if (resp_start) begin
            bit_cnt_q <= CntWidth'(1);  // Start bit already taken
            state_q   <= ST_RECV;
          end else if (sd_rise_i) begin
            if (wait_cnt_q == ToWidth'(RespTimeout - 1)) begin
              cmd_err_o[ERR_TIMEOUT] <= 1'b1;
              state_q                <= ST_DONE;
            end else begin
              wait_cnt_q <= wait_cnt_q + 1'b1;
            end
          end
        end
        ST_RECV: begin
          if (recv_bit) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == CntWidth'(END_BIT_POS)) begin
              cmd_err_o[ERR_CRC]     <= rx_crc != crc_q;
              cmd_err_o[ERR_END_BIT] <= sd_cmd_i != END_BIT;
              cmd_err_o[ERR_INDEX]   <= rx_index != sent_index_q;  // Echo must match
              state_q                <= ST_DONE;
            end
          end
        end
        ST_DONE: state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign cmd_busy_o = (state_q != ST_IDLE);
  assign cmd_done_o = (state_q == ST_DONE);

endmodule

// File: source/sdhc_clk_div.sv
// ======================================
// SD clock divider with edge strobes
// ======================================
`timescale 1ns/10ps

module sdhc_clk_div #(
  parameter int DivWidth = 8
) (
  input  logic                clk_i,
  input  logic                software_reset_cmd_q,
  input  logic [DivWidth-1:0] div_i,
  input  logic                clk_en_i,
  output logic                sd_clk_o,
  output logic                sd_rise_o,
  output logic                sd_fall_o,
  output logic                sd_stable_o
);

  logic [DivWidth-1:0] cnt_q;
  logic                tick;

  // Strobes mark the clk_i cycle that ends with the SD clock edge
  assign tick      = clk_en_i && (cnt_q >= div_i);
  assign sd_rise_o = tick && !sd_clk_o;
  assign sd_fall_o = tick && sd_clk_o;

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      cnt_q       <= '0;
      sd_clk_o    <= 1'b0;
      sd_stable_o <= 1'b0;
    end else begin
      sd_stable_o <= clk_en_i;
      if (!clk_en_i) begin
        cnt_q    <= '0;
        sd_clk_o <= 1'b0;  // Parked low
      end else if (tick) begin
        cnt_q    <= '0;
        sd_clk_o <= !sd_clk_o;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: source/sdhc_regs.sv
// ======================================
// Register file, interrupt status/enable
// Command start, inhibit and soft reset
// ======================================
`timescale 1ns/10ps

module sdhc_regs
  import sdhc_reg_pkg::*;
  import sdhc_cmd_pkg::*;
#(
  parameter int DivWidth = 8
) (
  input  logic                clk_i,
  input  logic                software_reset_cmd_q,
  input  logic                reg_we_i,
  input  logic                reg_re_i,
  input  reg_addr_t           reg_addr_i,
  input  reg_data_t           reg_wdata_i,
  output reg_data_t           reg_rdata_o,
  output logic                reg_rvalid_o,
  input  logic                sd_stable_i,
  input  logic                cmd_busy_i,
  input  logic                cmd_done_i,
  input  cmd_err_t            cmd_err_i,
  input  reg_data_t           resp_status_i,
  output logic                cmd_start_o,
  output cmd_index_t          cmd_index_o,
  output reg_data_t           cmd_arg_o,
  output logic                resp_en_o,
  output logic [DivWidth-1:0] div_o,
  output logic                clk_en_o,
  output logic                soft_rst_cmd_o,
  output logic                interrupt_o
);

  logic [INT_BITS-1:0] int_status_q;
  logic [INT_BITS-1:0] int_enable_q;
  logic [INT_BITS-1:0] int_set;
  logic [INT_BITS-1:0] int_clr;
  logic                inhibit;
  logic                wr_command;
  logic                wr_soft_rst;
  reg_data_t           rdata;

  // Pending start or soft reset counts as busy
  assign inhibit = cmd_busy_i | cmd_start_o | soft_rst_cmd_o;

  assign wr_command  = reg_we_i && (reg_addr_i == ADDR_COMMAND);
  assign wr_soft_rst = reg_we_i && (reg_addr_i == ADDR_SOFT_RESET);
  assign int_clr     = (reg_we_i && (reg_addr_i == ADDR_INT_STATUS)) ?
                       reg_wdata_i[INT_BITS-1:0] : '0;

  always_comb begin
    int_set = '0;
    if (cmd_done_i) begin
      int_set[INT_CMD_COMPLETE] = !cmd_err_i[ERR_TIMEOUT];
      int_set[INT_TIMEOUT]      = cmd_err_i[ERR_TIMEOUT];
      int_set[INT_CRC]          = cmd_err_i[ERR_CRC];
      int_set[INT_END_BIT]      = cmd_err_i[ERR_END_BIT];
      int_set[INT_INDEX]        = cmd_err_i[ERR_INDEX];
    end
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      cmd_arg_o    <= '0;
      cmd_index_o  <= '0;
      resp_en_o    <= 1'b0;
      div_o        <= '0;
      clk_en_o     <= 1'b0;
      int_enable_q <= '0;
    end else if (reg_we_i) begin
      case (reg_addr_i)
        ADDR_ARGUMENT: cmd_arg_o <= reg_wdata_i;
        ADDR_COMMAND: begin
          if (!inhibit) begin  // Dropped while a command runs
            cmd_index_o <= reg_wdata_i[CMD_INDEX_LSB +: INDEX_BITS];
            resp_en_o   <= reg_wdata_i[CMD_RESP_EN_BIT];
          end
        end
        ADDR_CLOCK_CTRL: begin
          div_o    <= reg_wdata_i[CLK_DIV_LSB +: DivWidth];
          clk_en_o <= reg_wdata_i[CLK_EN_BIT];
        end
        ADDR_INT_ENABLE: int_enable_q <= reg_wdata_i[INT_BITS-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      cmd_start_o    <= 1'b0;
      soft_rst_cmd_o <= 1'b0;
      int_status_q   <= '0;
      interrupt_o    <= 1'b0;
      reg_rvalid_o   <= 1'b0;
    end else begin
      cmd_start_o    <= wr_command && !inhibit;
      // One-cycle pulse, also fired by a response timeout
      soft_rst_cmd_o <= (wr_soft_rst && reg_wdata_i[SOFT_RST_CMD_BIT]) || int_set[INT_TIMEOUT];
      int_status_q   <= (int_status_q & ~int_clr) | int_set;  // Set wins over W1C
      interrupt_o    <= |(int_status_q & int_enable_q);
      reg_rvalid_o   <= reg_re_i;
    end
  end

  always_comb begin
    rdata = '0;
    case (reg_addr_i)
      ADDR_ARGUMENT: rdata = cmd_arg_o;
      ADDR_COMMAND: begin
        rdata[CMD_INDEX_LSB +: INDEX_BITS] = cmd_index_o;
        rdata[CMD_RESP_EN_BIT]             = resp_en_o;
      end
      ADDR_RESPONSE: rdata = resp_status_i;
      ADDR_CLOCK_CTRL: begin
        rdata[CLK_DIV_LSB +: DivWidth] = div_o;
        rdata[CLK_EN_BIT]              = clk_en_o;
        rdata[CLK_STABLE_BIT]          = sd_stable_i;
      end
      ADDR_SOFT_RESET: rdata[SOFT_RST_CMD_BIT]    = soft_rst_cmd_o;
      ADDR_INT_STATUS: rdata[INT_BITS-1:0]        = int_status_q;
      ADDR_INT_ENABLE: rdata[INT_BITS-1:0]        = int_enable_q;
      ADDR_PRESENT:    rdata[PRESENT_INHIBIT_BIT] = inhibit;
      default:         rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reg_re_i) begin
      reg_rdata_o <= rdata;
    end
  end

endmodule

// File: source/sdhc_cmd_pkg.sv
// ======================================
// SD command frame layout and CRC7 step
// ======================================
package sdhc_cmd_pkg;

  localparam int FRAME_BITS  = 48;
  localparam int INDEX_BITS  = 6;
  localparam int CRC_BITS    = 7;
  localparam int CRC_FIRST   = FRAME_BITS - CRC_BITS - 1;  // Bits before the CRC field
  localparam int END_BIT_POS = FRAME_BITS - 1;

  localparam logic START_BIT = 1'b0;
  localparam logic END_BIT   = 1'b1;
  localparam logic DIR_HOST  = 1'b1;  // Transmission bit, host to card

  typedef logic [INDEX_BITS-1:0] cmd_index_t;
  typedef logic [CRC_BITS-1:0]   crc7_t;

  // x^7 + x^3 + 1, top term implied
  localparam crc7_t CRC7_POLY = 7'h09;

  // Shifts one frame bit through the CRC7 register
  function automatic crc7_t crc7_next(crc7_t crc, logic bit_in);
    logic  fb;
    crc7_t shifted;
    fb      = crc[CRC_BITS-1] ^ bit_in;
    shifted = {crc[CRC_BITS-2:0], 1'b0};
    if (fb) begin
      shifted = shifted ^ CRC7_POLY;
    end
    return shifted;
  endfunction

endpackage

// File: source/sdhc_reg_pkg.sv
// ======================================
// Register map of the SD host controller
// Addresses, field positions, bus types
// ======================================
package sdhc_reg_pkg;

  localparam int REG_ADDR_BITS = 3;
  localparam int REG_DATA_BITS = 32;

  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [REG_DATA_BITS-1:0] reg_data_t;

  localparam reg_addr_t ADDR_ARGUMENT   = 3'd0;
  localparam reg_addr_t ADDR_COMMAND    = 3'd1;
  localparam reg_addr_t ADDR_RESPONSE   = 3'd2;
  localparam reg_addr_t ADDR_CLOCK_CTRL = 3'd3;
  localparam reg_addr_t ADDR_SOFT_RESET = 3'd4;
  localparam reg_addr_t ADDR_INT_STATUS = 3'd5;
  localparam reg_addr_t ADDR_INT_ENABLE = 3'd6;
  localparam reg_addr_t ADDR_PRESENT    = 3'd7;

  localparam int CMD_INDEX_LSB   = 0;
  localparam int CMD_RESP_EN_BIT = 8;

  localparam int CLK_DIV_LSB    = 0;
  localparam int CLK_EN_BIT     = 8;
  localparam int CLK_STABLE_BIT = 9;  // Read only

  localparam int SOFT_RST_CMD_BIT = 0;

  localparam int INT_CMD_COMPLETE = 0;
  localparam int INT_TIMEOUT      = 1;
  localparam int INT_CRC          = 2;
  localparam int INT_END_BIT      = 3;
  localparam int INT_INDEX        = 4;
  localparam int INT_BITS         = 5;

  localparam int PRESENT_INHIBIT_BIT = 0;

  // One flag per response error kind
  localparam int ERR_TIMEOUT = 0;
  localparam int ERR_CRC     = 1;
  localparam int ERR_END_BIT = 2;
  localparam int ERR_INDEX   = 3;
  localparam int ERR_BITS    = 4;

  typedef logic [ERR_BITS-1:0] cmd_err_t;

endpackage
